/* list.f */
+incdir+src
src/frontEndPkg.sv
src/multiPortRam.sv
src/instDecoder.sv
src/instBuffer.sv
src/dispatchPort.sv
src/frontEnd.sv
verif/frontEndTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the front-end testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f list.f --top-module frontEndTb --Mdir "$BUILD_DIR" -o frontEndSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/frontEndSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
exit 0

/* src/dispatchPort.sv */
`default_nettype none

module dispatchPort (
  input  wire logic                         clk,
  input  wire logic                         reset_i,
  input  wire logic                         groupReady_i,
  input  wire frontEndPkg::dispatchGroup_t  group_i,
  output logic                              portBusy_o,
  output logic                              dispReq_o,
  input  wire logic                         dispAck_i,
  output frontEndPkg::dispatchGroup_t       dispGroup_o
);

  frontEndPkg::dispState_e state;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state <= frontEndPkg::DISP_IDLE;
    end else begin
      case (state)
        frontEndPkg::DISP_IDLE: begin
          if (groupReady_i) state <= frontEndPkg::DISP_REQ;  // buffer pops now.
        end
        frontEndPkg::DISP_REQ: begin
          if (dispAck_i) state <= frontEndPkg::DISP_RELEASE;  // receiver took it.
        end
        frontEndPkg::DISP_RELEASE: begin
          if (!dispAck_i) state <= frontEndPkg::DISP_IDLE;  // delivery ends.
        end
        default: state <= frontEndPkg::DISP_IDLE;
      endcase
    end
  end

  // group held stable from capture until back in idle.
  always_ff @(posedge clk) begin
    if (state == frontEndPkg::DISP_IDLE && groupReady_i) begin
      dispGroup_o <= group_i;
    end
  end

  assign portBusy_o = (state != frontEndPkg::DISP_IDLE);
  assign dispReq_o  = (state == frontEndPkg::DISP_REQ);  // drops once ack is seen.

endmodule

`default_nettype wire

/* src/frontEnd.sv */
`default_nettype none

module frontEnd (
  input  wire logic                         clk,
  input  wire logic                         reset_i,
  input  wire logic                         flush_i,
  input  wire logic                         fetchValid_i,
  input  wire frontEndPkg::fetchBundle_t    fetch_i,
  output logic                              stallFetch_o,
  output logic                              dispReq_o,
  input  wire logic                         dispAck_i,
  output frontEndPkg::dispatchGroup_t       dispGroup_o
);

  logic                        decValid;    // decoder register valid.
  frontEndPkg::decodedBundle_t decoded;     // decoded lanes.
  logic                        groupReady;  // four or more queued.
  frontEndPkg::dispatchGroup_t group;       // head window.
  logic                        portBusy;    // handshake in progress.

  instDecoder decoder0 (
    .clk          (clk),
    .reset_i      (reset_i),
    .flush_i      (flush_i),
    .fetchValid_i (fetchValid_i),
    .stallFetch_i (stallFetch_o),
    .fetch_i      (fetch_i),
    .decValid_o   (decValid),
    .decoded_o    (decoded)
  );

  instBuffer buffer0 (
    .clk          (clk),
    .reset_i      (reset_i),
    .flush_i      (flush_i),
    .decValid_i   (decValid),
    .decoded_i    (decoded),
    .portBusy_i   (portBusy),
    .stallFetch_o (stallFetch_o),
    .groupReady_o (groupReady),
    .group_o      (group)
  );

  // no flush here, a captured group always completes.
  dispatchPort port0 (
    .clk          (clk),
    .reset_i      (reset_i),
    .groupReady_i (groupReady),
    .group_i      (group),
    .portBusy_o   (portBusy),
    .dispReq_o    (dispReq_o),
    .dispAck_i    (dispAck_i),
    .dispGroup_o  (dispGroup_o)
  );

endmodule

`default_nettype wire

/* src/frontEndPkg.sv */
`include "ibuf_cfg.svh"
`default_nettype none

package frontEndPkg;

  // instruction class, same code as raw bits 31..29 where legal.
  typedef enum logic [`IB_OPC_WIDTH-1:0] {
    OP_ALU     = 3'd0,
    OP_LOAD    = 3'd1,
    OP_STORE   = 3'd2,
    OP_BRANCH  = 3'd3,
    OP_JUMP    = 3'd4,
    OP_ILLEGAL = 3'd7
  } opcode_e;

  // four-phase dispatch handshake states.
  typedef enum logic [1:0] {
    DISP_IDLE    = 2'd0,  // free, waiting for a group.
    DISP_REQ     = 2'd1,  // req high, waiting for ack.
    DISP_RELEASE = 2'd2   // req low, waiting for ack to fall.
  } dispState_e;

  typedef struct packed {
    logic [`IB_PC_WIDTH-1:0]                        pc;     // lane 0 pc.
    logic [`IB_FETCH_WIDTH-1:0]                     valid;  // lane valid mask.
    logic [`IB_FETCH_WIDTH-1:0][`IB_INST_WIDTH-1:0] inst;   // raw words.
  } fetchBundle_t;

  typedef struct packed {
    logic [`IB_PC_WIDTH-1:0]  pc;
    opcode_e                  opcode;
    logic [`IB_REG_LOG-1:0]   rd;
    logic [`IB_REG_LOG-1:0]   rs1;
    logic [`IB_REG_LOG-1:0]   rs2;
    logic [`IB_IMM_WIDTH-1:0] imm;
  } decodedInst_t;

  typedef struct packed {
    decodedInst_t [`IB_FETCH_WIDTH-1:0] inst;   // one record per lane.
    logic [`IB_FETCH_WIDTH-1:0]         valid;  // copied from the bundle.
  } decodedBundle_t;

  typedef struct packed {
    decodedInst_t [`IB_DISPATCH_WIDTH-1:0] inst;         // oldest in slot 0.
    logic [`IB_BRCNT_WIDTH-1:0]            branchCount;  // branches plus jumps.
  } dispatchGroup_t;

endpackage

`default_nettype wire

/* src/ibuf_cfg.svh */
`ifndef IBUF_CFG_SVH
`define IBUF_CFG_SVH

// front-end sizes.
`define IB_FETCH_WIDTH     8   // lanes per fetch bundle.
`define IB_DISPATCH_WIDTH  4   // records per dispatch group.
`define IB_QUEUE_DEPTH     32  // queue entries.
`define IB_QUEUE_LOG       5   // queue pointer width.

// field widths.
`define IB_PC_WIDTH        32  // program counter.
`define IB_INST_WIDTH      32  // raw instruction word.
`define IB_REG_LOG         5   // register index.
`define IB_IMM_WIDTH       14  // immediate, no sign extension.
`define IB_OPC_WIDTH       3   // instruction class field.
`define IB_BRCNT_WIDTH     3   // branch count of one group, up to 4.

`endif

/* src/instBuffer.sv */
`include "ibuf_cfg.svh"
`default_nettype none

module instBuffer (
  input  wire logic                         clk,
  input  wire logic                         reset_i,
  input  wire logic                         flush_i,
  input  wire logic                         decValid_i,
  input  wire frontEndPkg::decodedBundle_t  decoded_i,
  input  wire logic                         portBusy_i,
  output logic                              stallFetch_o,
  output logic                              groupReady_o,
  output frontEndPkg::dispatchGroup_t       group_o
);

  localparam logic [`IB_QUEUE_LOG:0] GroupSize  = `IB_DISPATCH_WIDTH;
  localparam logic [`IB_QUEUE_LOG:0] StallLevel =
    `IB_QUEUE_DEPTH - 2 * `IB_FETCH_WIDTH;  // room for two bundles.

  logic [`IB_QUEUE_LOG-1:0] headPtr;    // oldest entry.
  logic [`IB_QUEUE_LOG-1:0] tailPtr;    // next free entry.
  logic [`IB_QUEUE_LOG:0]   instCount;  // occupancy, 0 to depth.

  logic [`IB_FETCH_WIDTH-1:0]                        writeEn;
  logic [`IB_FETCH_WIDTH-1:0][`IB_QUEUE_LOG-1:0]     writeAddr;
  logic [`IB_QUEUE_LOG:0]                            writeCount;
  logic [`IB_DISPATCH_WIDTH-1:0][`IB_QUEUE_LOG-1:0]  readAddr;
  frontEndPkg::decodedInst_t [`IB_DISPATCH_WIDTH-1:0] readData;
  logic                                              popGroup;
  logic [`IB_BRCNT_WIDTH-1:0]                        branchCount;

  multiPortRam #(
    .Depth    (`IB_QUEUE_DEPTH),
    .LogDepth (`IB_QUEUE_LOG),
    .Width    ($bits(frontEndPkg::decodedInst_t))
  ) queueRam (
    .clk     (clk),
    .we_i    (writeEn),
    .waddr_i (writeAddr),
    .wdata_i (decoded_i.inst),
    .raddr_i (readAddr),
    .rdata_o (readData)
  );

  // prefix count of the valid mask.
  // each valid lane goes to the tail plus the number of valid lanes below it.
  always_comb begin : writeSlots
    logic [`IB_QUEUE_LOG:0] slot;
    slot = '0;
    for (int k = 0; k < `IB_FETCH_WIDTH; k++) begin
      writeEn[k]   = decValid_i & decoded_i.valid[k];  // never refused.
      writeAddr[k] = tailPtr + slot[`IB_QUEUE_LOG-1:0];  // wraps on depth.
      slot         = slot + {{`IB_QUEUE_LOG{1'b0}}, writeEn[k]};
    end
    writeCount = slot;  // records written this cycle.
  end

  // head window and its branch count.
  always_comb begin
    branchCount = '0;
    for (int r = 0; r < `IB_DISPATCH_WIDTH; r++) begin
      readAddr[r] = headPtr + `IB_QUEUE_LOG'(r);
      if (readData[r].opcode == frontEndPkg::OP_BRANCH ||
          readData[r].opcode == frontEndPkg::OP_JUMP) begin
        branchCount = branchCount + 1'b1;
      end
    end
  end

  assign groupReady_o      = (instCount >= GroupSize);  // full group waiting.
  assign popGroup          = groupReady_o & ~portBusy_i;  // port captures on this edge.
  assign stallFetch_o      = (instCount > StallLevel);
  assign group_o.inst        = readData;
  assign group_o.branchCount = branchCount;

  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0;
    end else begin
      tailPtr <= tailPtr + writeCount[`IB_QUEUE_LOG-1:0];
      if (popGroup) begin
        headPtr <= headPtr + GroupSize[`IB_QUEUE_LOG-1:0];
      end
      instCount <= instCount + writeCount - (popGroup ? GroupSize : '0);  // net change.
    end
  end

endmodule

`default_nettype wire

/* src/instDecoder.sv */
`include "ibuf_cfg.svh"
`default_nettype none

module instDecoder (
  input  wire logic                         clk,
  input  wire logic                         reset_i,
  input  wire logic                         flush_i,
  input  wire logic                         fetchValid_i,
  input  wire logic                         stallFetch_i,
  input  wire frontEndPkg::fetchBundle_t    fetch_i,
  output logic                              decValid_o,
  output frontEndPkg::decodedBundle_t       decoded_o
);

  logic acceptBundle;

  // one raw word into one record.
  function automatic frontEndPkg::decodedInst_t decodeLane(
    input logic [`IB_INST_WIDTH-1:0] raw,
    input logic [`IB_PC_WIDTH-1:0]   lanePc
  );
    frontEndPkg::decodedInst_t rec;
    rec.pc = lanePc;
    case (raw[`IB_INST_WIDTH-1 -: `IB_OPC_WIDTH])  // class in the top bits.
      3'd0:    rec.opcode = frontEndPkg::OP_ALU;
      3'd1:    rec.opcode = frontEndPkg::OP_LOAD;
      3'd2:    rec.opcode = frontEndPkg::OP_STORE;
      3'd3:    rec.opcode = frontEndPkg::OP_BRANCH;
      3'd4:    rec.opcode = frontEndPkg::OP_JUMP;
      default: rec.opcode = frontEndPkg::OP_ILLEGAL;  // classes 5 to 7.
    endcase
    rec.rd  = raw[`IB_IMM_WIDTH + 2*`IB_REG_LOG +: `IB_REG_LOG];  // bits 28..24.
    rec.rs1 = raw[`IB_IMM_WIDTH + `IB_REG_LOG +: `IB_REG_LOG];    // bits 23..19.
    rec.rs2 = raw[`IB_IMM_WIDTH +: `IB_REG_LOG];                  // bits 18..14.
    rec.imm = raw[`IB_IMM_WIDTH-1:0];                             // bits 13..0.
    return rec;
  endfunction

  assign acceptBundle = fetchValid_i & ~stallFetch_i;  // fetch holds while stalled.

  // control, cleared by reset or flush.
  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      decValid_o <= 1'b0;
    end else begin
      decValid_o <= acceptBundle;  // one cycle after the bundle is taken.
    end
  end

  // payload, loaded only on an accepted bundle.
  always_ff @(posedge clk) begin
    if (acceptBundle) begin
      decoded_o.valid <= fetch_i.valid;
      for (int k = 0; k < `IB_FETCH_WIDTH; k++) begin
        decoded_o.inst[k] <= decodeLane(fetch_i.inst[k],
                                        fetch_i.pc + `IB_PC_WIDTH'(4 * k));  // base plus 4k.
      end
    end
  end

endmodule

`default_nettype wire

/* src/multiPortRam.sv */
`include "ibuf_cfg.svh"
`default_nettype none

module multiPortRam #(
  parameter int Depth    = 32,  // entries.
  parameter int LogDepth = 5,   // address width.
  parameter int Width    = 64   // bits per entry.
) (
  input  wire logic                                       clk,

  // write side, one port per fetch lane.
  input  wire logic [`IB_FETCH_WIDTH-1:0]                 we_i,
  input  wire logic [`IB_FETCH_WIDTH-1:0][LogDepth-1:0]   waddr_i,
  input  wire logic [`IB_FETCH_WIDTH-1:0][Width-1:0]      wdata_i,

  // read side, one port per dispatch slot.
  input  wire logic [`IB_DISPATCH_WIDTH-1:0][LogDepth-1:0] raddr_i,
  output logic [`IB_DISPATCH_WIDTH-1:0][Width-1:0]         rdata_o
);

  logic [Width-1:0] mem [Depth];  // register array, no reset.

  // all enabled ports write in the same cycle.
  // addresses differ since they are consecutive slots after the tail.
  always_ff @(posedge clk) begin
    for (int w = 0; w < `IB_FETCH_WIDTH; w++) begin
      if (we_i[w]) begin
        mem[waddr_i[w]] <= wdata_i[w];
      end
    end
  end

  // asynchronous read.
  always_comb begin
    for (int r = 0; r < `IB_DISPATCH_WIDTH; r++) begin
      rdata_o[r] = mem[raddr_i[r]];  // new writes show up next cycle.
    end
  end

endmodule

`default_nettype wire

/* verif/frontEndTb.sv */
`include "ibuf_cfg.svh"
`default_nettype none

module frontEndTb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [3:0]      numBundles;
    logic [7:0][7:0] masks;        // mask of bundle b in masks[b].
    logic [31:0]     pcBase;
    logic [7:0]      ackDelay;     // cycles from req to ack.
    logic            flushAfter;
    logic            laneClass;    // class field forced to the lane index.
    logic            expectStall;
  } testEntry_t;

  localparam int NumTests  = 7;
  localparam int WaitLimit = 2000;  // cycles per wait loop.

  string testName [NumTests] = '{"in-order full bundles", "field decode", "branch counts",
    "sparse masks", "back-pressure", "flush in flight", "stream after flush"};
  testEntry_t testTable [NumTests] = '{
    '{4'd4, {8{8'hff}}, 32'h0000_1000, 8'd1, 1'b0, 1'b0, 1'b0},
    '{4'd3, {8{8'hff}}, 32'h0000_2000, 8'd2, 1'b0, 1'b1, 1'b0},
    '{4'd4, {8{8'hff}}, 32'h0000_3000, 8'd0, 1'b0, 1'b0, 1'b0},
    '{4'd5, {24'h0, 8'h09, 8'he7, 8'h00, 8'h16, 8'h81}, 32'h0000_4000, 8'd3, 1'b0, 1'b0, 1'b0},
    '{4'd8, {8'h7f, {7{8'hff}}}, 32'h0000_5000, 8'd40, 1'b0, 1'b0, 1'b1},
    '{4'd3, {8{8'hff}}, 32'h0000_8000, 8'd12, 1'b1, 1'b0, 1'b0},
    '{4'd4, {32'h0, 8'hc3, 8'hff, 8'h3c, 8'hff}, 32'h0000_9000, 8'd3, 1'b0, 1'b0, 1'b0}
  };

  logic                        clk;
  logic                        reset_i;
  logic                        flush_i;
  logic                        fetchValid_i;
  frontEndPkg::fetchBundle_t   fetch_i;
  logic                        stallFetch_o;
  logic                        dispReq_o;
  logic                        dispAck_i;
  frontEndPkg::dispatchGroup_t dispGroup_o;

  frontEndPkg::decodedInst_t refQ [$];  // accepted records, oldest first.
  int   errors     = 0;
  int   groupsSeen = 0;
  int   ackDelay   = 0;
  logic rxActive;   // responder inside a handshake.
  logic stallSeen;  // stall observed during the current test.

  frontEnd dut0 (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;  // 8 ns period.

  // reference decode, straight from the bit layout.
  function automatic frontEndPkg::decodedInst_t expectRecord(input logic [31:0] raw,
                                                             input logic [31:0] pc);
    frontEndPkg::decodedInst_t rec;
    rec.pc = pc;
    case (raw[31:29])
      3'd0:    rec.opcode = frontEndPkg::OP_ALU;
      3'd1:    rec.opcode = frontEndPkg::OP_LOAD;
      3'd2:    rec.opcode = frontEndPkg::OP_STORE;
      3'd3:    rec.opcode = frontEndPkg::OP_BRANCH;
      3'd4:    rec.opcode = frontEndPkg::OP_JUMP;
      default: rec.opcode = frontEndPkg::OP_ILLEGAL;
    endcase
    rec.rd  = raw[28:24];
    rec.rs1 = raw[23:19];
    rec.rs2 = raw[18:14];
    rec.imm = raw[13:0];
    return rec;
  endfunction

  // compares the offered group with the four oldest expected records.
  task automatic checkGroup();
    int branches;
    frontEndPkg::decodedInst_t exp;
    branches = 0;
    if (refQ.size() < `IB_DISPATCH_WIDTH) begin
      errors++;
      $display("ERROR: dispatch request at %0t with only %0d records expected",
               $time, refQ.size());
    end else begin
      for (int s = 0; s < `IB_DISPATCH_WIDTH; s++) begin
        exp = refQ.pop_front();
        if (exp.opcode == frontEndPkg::OP_BRANCH || exp.opcode == frontEndPkg::OP_JUMP)
          branches++;
        assert (dispGroup_o.inst[s] == exp) else begin
          errors++;
          $display("CHECK FAILED at %0t ns: slot %0d pc %h got %h expected %h",
                   $time, s, exp.pc, dispGroup_o.inst[s], exp);
        end
      end
      assert (dispGroup_o.branchCount == 3'(branches)) else begin
        errors++;
        $display("CHECK FAILED at %0t ns: branchCount %0d expected %0d",
                 $time, dispGroup_o.branchCount, branches);
      end
    end
  endtask

  task automatic sendBundle(input testEntry_t e, input int b);
    int waitCnt;
    logic [31:0] bundlePc;
    waitCnt  = 0;
    bundlePc = e.pcBase + 32'(32 * b);
    while (stallFetch_o && waitCnt < WaitLimit) begin  // hold the bundle back.
      stallSeen = 1'b1;
      @(negedge clk);
      waitCnt++;
    end
    if (waitCnt >= WaitLimit) begin
      errors++;
      $display("ERROR: fetch stall did not clear within %0d cycles", WaitLimit);
    end
    fetch_i.pc    = bundlePc;
    fetch_i.valid = e.masks[b];
    for (int k = 0; k < `IB_FETCH_WIDTH; k++) begin
      fetch_i.inst[k] = $urandom();
      if (e.laneClass) fetch_i.inst[k][31:29] = 3'(k);  // every class once.
      if (e.masks[b][k]) refQ.push_back(expectRecord(fetch_i.inst[k], bundlePc + 32'(4 * k)));
    end
    fetchValid_i = 1'b1;  // taken at the next rising edge.
    @(negedge clk);
    fetchValid_i = 1'b0;
  endtask

  task automatic applyFlush();
    int waitCnt;
    waitCnt = 0;
    while (!rxActive && waitCnt < WaitLimit) begin  // a group must sit in the port.
      @(negedge clk);
      waitCnt++;
    end
    if (waitCnt >= WaitLimit) begin
      errors++;
      $display("ERROR: no dispatch request appeared before the flush");
    end
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    refQ.delete();  // queued and in-flight records are gone.
  endtask

  task automatic waitDrain();
    int waitCnt;
    waitCnt = 0;
    while ((refQ.size() >= `IB_DISPATCH_WIDTH || rxActive) && waitCnt < WaitLimit) begin
      @(negedge clk);
      waitCnt++;
    end
    if (waitCnt >= WaitLimit) begin
      errors++;
      $display("ERROR: dispatch did not drain, %0d records still expected", refQ.size());
    end
  endtask

  // receiver side of the four-phase handshake.
  initial begin : ackResponder
    int waitCnt;
    frontEndPkg::dispatchGroup_t held;
    dispAck_i = 1'b0;
    rxActive  = 1'b0;
    forever begin
      @(negedge clk);
      if (!reset_i && dispReq_o) begin
        rxActive = 1'b1;
        held     = dispGroup_o;
        checkGroup();
        for (int d = 0; d < ackDelay; d++) begin
          @(negedge clk);
          assert (dispReq_o && dispGroup_o == held) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: req or group changed before ack", $time);
          end
        end
        dispAck_i = 1'b1;
        waitCnt   = 0;
        while (dispReq_o && waitCnt < WaitLimit) begin  // req drops once ack is seen.
          @(negedge clk);
          waitCnt++;
        end
        if (waitCnt >= WaitLimit) begin
          errors++;
          $display("ERROR: dispatch req stayed high after ack");
        end
        dispAck_i = 1'b0;  // end of this delivery.
        rxActive  = 1'b0;
        groupsSeen++;
      end
    end
  end

  initial begin : mainFlow
    int errorsBefore;
    int groupsBefore;
    int testsFailed;
    void'($urandom(32'hef14f5d9));  // seeds the instruction words.
    testsFailed  = 0;
    reset_i      = 1'b1;
    flush_i      = 1'b0;
    fetchValid_i = 1'b0;
    fetch_i      = '0;
    repeat (10) @(negedge clk);
    reset_i = 1'b0;
    for (int t = 0; t < NumTests; t++) begin
      errorsBefore = errors;
      groupsBefore = groupsSeen;
      stallSeen    = 1'b0;
      ackDelay     = int'(testTable[t].ackDelay);
      if (t == 0) begin
        assert (!dispReq_o && !stallFetch_o) else begin
          errors++;
          $display("CHECK FAILED at %0t ns: req or stall high after reset", $time);
        end
      end
      for (int b = 0; b < int'(testTable[t].numBundles); b++) sendBundle(testTable[t], b);
      if (testTable[t].flushAfter) applyFlush();
      waitDrain();
      for (int q = 0; q < 8; q++) begin  // a partial group is never offered.
        @(negedge clk);
        assert (!dispReq_o) else begin
          errors++;
          $display("CHECK FAILED at %0t ns: request with %0d records queued", $time, refQ.size());
        end
      end
      if (testTable[t].expectStall) begin
        assert (stallSeen) else begin
          errors++;
          $display("CHECK FAILED at %0t ns: stallFetch_o never rose under back-pressure", $time);
        end
      end
      if (testTable[t].flushAfter) begin
        assert (groupsSeen - groupsBefore == 1) else begin
          errors++;
          $display("CHECK FAILED at %0t ns: %0d groups around the flush, expected 1",
                   $time, groupsSeen - groupsBefore);
        end
      end
      if (errors != errorsBefore) testsFailed++;
      $display("test %0d %s: %s, %0d groups", t, testName[t],
               (errors == errorsBefore) ? "passed" : "failed", groupsSeen - groupsBefore);
    end
    assert (refQ.size() == 0) else begin
      errors++;
      $display("CHECK FAILED at %0t ns: %0d records never dispatched", $time, refQ.size());
    end
    $display("summary: %0d tests, %0d failed, %0d errors, %0d groups",
             NumTests, testsFailed, errors, groupsSeen);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
